// ==== hdl/bltPkg.sv ====
/*
 * Blitter shared definitions
 * Word widths, host register map, control word and HOP/OP fields
 */
`default_nettype none

package bltPkg;

	localparam int DataBits = 16;		// Host and memory word
	localparam int IncrBits = 15;		// Increment keeps byte bits 15..1
	localparam int LineBits = 4;		// Line counter, halftone index

	typedef logic [DataBits-1:0] dataT;
	typedef logic signed [IncrBits-1:0] incrT;
	typedef logic [4:0] regIdxT;		// 0..15 halftone RAM, 16 up registers
	typedef logic [3:0] opT;		// Logic op, indexed by inverted source/dest
	typedef logic [1:0] hopT;		// Bit 1 source, bit 0 halftone

	// Register word indices, in ST order after the halftone RAM
	localparam regIdxT RegSrcXinc = 5'd16;
	localparam regIdxT RegSrcYinc = 5'd17;
	localparam regIdxT RegSrcHi   = 5'd18;
	localparam regIdxT RegSrcLo   = 5'd19;
	localparam regIdxT RegMaskL   = 5'd20;
	localparam regIdxT RegMaskC   = 5'd21;
	localparam regIdxT RegMaskR   = 5'd22;
	localparam regIdxT RegDstXinc = 5'd23;
	localparam regIdxT RegDstYinc = 5'd24;
	localparam regIdxT RegDstHi   = 5'd25;
	localparam regIdxT RegDstLo   = 5'd26;
	localparam regIdxT RegXcount  = 5'd27;
	localparam regIdxT RegYcount  = 5'd28;	// Write also restarts the word sequence
	localparam regIdxT RegHopOp   = 5'd29;
	localparam regIdxT RegCtrl    = 5'd30;

	// Control word fields
	localparam int CtrlBusyBit = 15;
	localparam int CtrlLineLsb = 8;		// LineBits wide

	// HOP sits in the upper byte of the HOP/OP word, OP in the low nibble
	localparam int HopLsb = 8;

endpackage

`default_nettype wire

// ==== hdl/bltRegs.sv ====
/*
 * Blitter host register file
 * Increments, endmasks, HOP/OP and control word with registered readback,
 * busy flag and the halftone line counter
 */
`timescale 1ns/1ps
`default_nettype none

module bltRegs #(
	parameter int AddrBits = 23
) (
	input wire Clks,
	input wire rst,
	input wire hostSel,
	input wire hostWr,
	input wire bltPkg::regIdxT hostIdx,
	input wire bltPkg::dataT hostWrData,
	input wire [AddrBits-1:0] srcAddr,
	input wire [AddrBits-1:0] dstAddr,
	input wire bltPkg::dataT xCount,
	input wire bltPkg::dataT yCount,
	input wire dstDone,
	input wire lastX,
	input wire blitEnd,
	output bltPkg::dataT hostRdData,
	output bltPkg::incrT srcXinc,
	output bltPkg::incrT srcYinc,
	output bltPkg::incrT dstXinc,
	output bltPkg::incrT dstYinc,
	output bltPkg::dataT addrLoadVal,
	output logic addrLoadSel,
	output bltPkg::dataT maskL,
	output bltPkg::dataT maskC,
	output bltPkg::dataT maskR,
	output bltPkg::hopT hop,
	output bltPkg::opT op,
	output logic [bltPkg::LineBits-1:0] lineNum,
	output logic busy,
	output logic blitReset,
	output logic htWrEn
);
	import bltPkg::*;

	localparam int LoBits = DataBits - 1;	// Address bits held by the low word

	logic hostWe, hostRe;
	dataT rdMux;

	assign hostWe = hostSel & hostWr;
	assign hostRe = hostSel & !hostWr;
	assign htWrEn = hostWe & !hostIdx[4];		// Halftone words are indices 0..15
	assign addrLoadVal = hostWrData;			// Counters and addresses load the raw word
	assign addrLoadSel = hostWe & (hostIdx inside {RegSrcHi, RegSrcLo, RegDstHi,
		RegDstLo, RegXcount, RegYcount});

	// Configuration registers
	always_ff @(posedge Clks) begin
		if (rst) begin
			{srcXinc, srcYinc, dstXinc, dstYinc} <= '0;
			{maskL, maskC, maskR} <= '0;
			hop <= '0;
			op <= '0;
		end else if (hostWe) begin
			case (hostIdx)
				RegSrcXinc: srcXinc <= hostWrData[DataBits-1:1];	// Bit 0 dropped, even only
				RegSrcYinc: srcYinc <= hostWrData[DataBits-1:1];
				RegDstXinc: dstXinc <= hostWrData[DataBits-1:1];
				RegDstYinc: dstYinc <= hostWrData[DataBits-1:1];
				RegMaskL: maskL <= hostWrData;
				RegMaskC: maskC <= hostWrData;
				RegMaskR: maskR <= hostWrData;
				RegHopOp: begin
					hop <= hostWrData[HopLsb +: 2];
					op <= hostWrData[3:0];
				end
				default: ;
			endcase
		end
	end

	// Busy flag, line counter and restart pulse
	always_ff @(posedge Clks) begin
		if (rst) begin
			busy <= 1'b0;
			lineNum <= '0;
			blitReset <= 1'b0;
		end else begin
			blitReset <= hostWe & (hostIdx == RegYcount);	// One cycle, after the write
			if (hostWe & (hostIdx == RegCtrl)) begin
				busy <= hostWrData[CtrlBusyBit];		// Zero here stops a running blit
				lineNum <= hostWrData[CtrlLineLsb +: LineBits];
			end else begin
				if (blitEnd)
					busy <= 1'b0;
				// Line steps on the last word write, direction follows dest Y
				if (dstDone & lastX)
					lineNum <= dstYinc[IncrBits-1] ? lineNum - 1'b1 : lineNum + 1'b1;
			end
		end
	end

	// Readback mux
	always_comb begin
		rdMux = '0;
		case (hostIdx)
			RegSrcXinc: rdMux = {srcXinc, 1'b0};
			RegSrcYinc: rdMux = {srcYinc, 1'b0};
			RegSrcHi: rdMux = dataT'(srcAddr[AddrBits-1:LoBits]);
			RegSrcLo: rdMux = {srcAddr[LoBits-1:0], 1'b0};
			RegMaskL: rdMux = maskL;
			RegMaskC: rdMux = maskC;
			RegMaskR: rdMux = maskR;
			RegDstXinc: rdMux = {dstXinc, 1'b0};
			RegDstYinc: rdMux = {dstYinc, 1'b0};
			RegDstHi: rdMux = dataT'(dstAddr[AddrBits-1:LoBits]);
			RegDstLo: rdMux = {dstAddr[LoBits-1:0], 1'b0};
			RegXcount: rdMux = xCount;
			RegYcount: rdMux = yCount;
			RegHopOp: begin
				rdMux[HopLsb +: 2] = hop;
				rdMux[3:0] = op;
			end
			RegCtrl: begin
				rdMux[CtrlBusyBit] = busy;
				rdMux[CtrlLineLsb +: LineBits] = lineNum;
			end
			default: ;		// Halftone RAM is write only
		endcase
	end

	always_ff @(posedge Clks) begin
		if (hostRe)
			hostRdData <= rdMux;
	end

endmodule

`default_nettype wire

// ==== hdl/bltAddrGen.sv ====
/*
 * Blitter address generator
 * X/Y word counters and source/destination address registers
 */
`timescale 1ns/1ps
`default_nettype none

module bltAddrGen #(
	parameter int AddrBits = 23
) (
	input wire Clks,
	input wire rst,
	input wire bltPkg::regIdxT hostIdx,
	input wire bltPkg::dataT hostWrData,
	input wire addrLoadSel,
	input wire bltPkg::incrT srcXinc,
	input wire bltPkg::incrT srcYinc,
	input wire bltPkg::incrT dstXinc,
	input wire bltPkg::incrT dstYinc,
	input wire srcDone,
	input wire dstDone,
	input wire srcPhase,
	output logic [AddrBits-1:0] srcAddr,
	output logic [AddrBits-1:0] dstAddr,
	output logic [AddrBits-1:0] memAddr,
	output bltPkg::dataT xCount,
	output bltPkg::dataT yCount,
	output logic lastX,
	output logic blitEnd
);
	import bltPkg::*;

	localparam int LoBits = DataBits - 1;
	localparam int HiBits = AddrBits - LoBits;	// Upper address bits in the high word

	dataT xStart;					// X reload value
	incrT srcInc, dstInc;
	logic [AddrBits-1:0] srcStep, dstStep;

	assign lastX = (xCount == dataT'(1));
	assign blitEnd = dstDone & lastX & (yCount == dataT'(1));	// Last word, last line

	// Y increment applies on the last word of a line
	assign srcInc = lastX ? srcYinc : srcXinc;
	assign dstInc = lastX ? dstYinc : dstXinc;
	assign srcStep = {{(AddrBits-IncrBits){srcInc[IncrBits-1]}}, srcInc};
	assign dstStep = {{(AddrBits-IncrBits){dstInc[IncrBits-1]}}, dstInc};

	assign memAddr = srcPhase ? srcAddr : dstAddr;

	// Word counters, step once per destination write
	always_ff @(posedge Clks) begin
		if (rst) begin
			xCount <= '0;
			yCount <= '0;
			xStart <= '0;
		end else if (addrLoadSel) begin
			if (hostIdx == RegXcount) begin
				xCount <= hostWrData;
				xStart <= hostWrData;
			end
			if (hostIdx == RegYcount)
				yCount <= hostWrData;
		end else if (dstDone) begin
			if (lastX) begin
				xCount <= xStart;		// New line
				yCount <= yCount - 1'b1;
			end else
				xCount <= xCount - 1'b1;
		end
	end

	// Address registers
	always_ff @(posedge Clks) begin
		if (rst) begin
			srcAddr <= '0;
			dstAddr <= '0;
		end else if (addrLoadSel) begin
			case (hostIdx)
				RegSrcHi: srcAddr[AddrBits-1:LoBits] <= hostWrData[HiBits-1:0];
				RegSrcLo: srcAddr[LoBits-1:0] <= hostWrData[DataBits-1:1];
				RegDstHi: dstAddr[AddrBits-1:LoBits] <= hostWrData[HiBits-1:0];
				RegDstLo: dstAddr[LoBits-1:0] <= hostWrData[DataBits-1:1];
				default: ;
			endcase
		end else begin
			if (srcDone)
				srcAddr <= srcAddr + srcStep;
			if (dstDone)
				dstAddr <= dstAddr + dstStep;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bltCore.sv ====
/*
 * Blitter data core
 * Halftone RAM, source/dest buffers, endmask select and HOP/OP logic
 */
`timescale 1ns/1ps
`default_nettype none

module bltCore (
	input wire Clks,
	input wire rst,
	input wire htWrEn,
	input wire bltPkg::regIdxT hostIdx,
	input wire bltPkg::dataT hostWrData,
	input wire [bltPkg::LineBits-1:0] lineNum,
	input wire bltPkg::dataT maskL,
	input wire bltPkg::dataT maskC,
	input wire bltPkg::dataT maskR,
	input wire bltPkg::hopT hop,
	input wire bltPkg::opT op,
	input wire bltPkg::dataT memRdData,
	input wire srcDone,
	input wire dstLatch,
	input wire dstDone,
	input wire lastX,
	input wire blitReset,
	output logic forceDstRd,
	output bltPkg::dataT blitWord
);
	import bltPkg::*;

	dataT htRam [2**LineBits];
	dataT htWord;					// Registered halftone, follows the line counter
	dataT srcBuf, dstBuf;
	dataT mask, hopWord;
	logic firstWord;				// Next word opens a line

	// Halftone RAM, host write port and synchronous read
	always_ff @(posedge Clks) begin
		if (htWrEn)
			htRam[hostIdx[LineBits-1:0]] <= hostWrData;
		htWord <= htRam[lineNum];
	end

	always_ff @(posedge Clks) begin
		if (srcDone)
			srcBuf <= memRdData;
		if (dstLatch)
			dstBuf <= memRdData;	// Read-modify-write operand
	end

	always_ff @(posedge Clks) begin
		if (rst | blitReset)
			firstWord <= 1'b1;
		else if (dstDone)
			firstWord <= lastX;		// Line wrap makes the next word a left one
	end

	// Left wins over right, so one-word lines use the left mask
	always_comb begin
		if (firstWord)
			mask = maskL;
		else if (lastX)
			mask = maskR;
		else
			mask = maskC;
	end

	assign forceDstRd = ~&mask;		// Any kept dest bit needs a read

	// HOP operand, unused inputs forced to ones
	assign hopWord = (hop[1] ? srcBuf : '1) & (hop[0] ? htWord : '1);

	// OP bit picked by inverted operand and dest, ST numbering (3 = source, 5 = dest)
	always_comb begin
		for (int i = 0; i < DataBits; i++) begin
			blitWord[i] = mask[i] ? op[{~hopWord[i], ~dstBuf[i]}] : dstBuf[i];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bltSequencer.sv ====
/*
 * Blitter sequencer
 * Per word read source, read dest, write dest FSM over a four-phase req/ack port
 */
`timescale 1ns/1ps
`default_nettype none

module bltSequencer (
	input wire Clks,
	input wire rst,
	input wire busy,
	input wire blitReset,
	input wire bltPkg::hopT hop,
	input wire bltPkg::opT op,
	input wire forceDstRd,
	input wire memAck,
	input wire bltPkg::dataT blitWord,
	output logic memReq,
	output logic memWr,
	output bltPkg::dataT memWrData,
	output logic srcDone,
	output logic dstDone,
	output logic srcPhase,
	output logic dstLatch
);

	localparam logic [1:0] SIdle = 2'd0;
	localparam logic [1:0] SRdSrc = 2'd1;
	localparam logic [1:0] SRdDst = 2'd2;
	localparam logic [1:0] SWrDst = 2'd3;

	logic [1:0] state, firstState, nextState;
	logic reqDone;					// Ack seen, waiting for it to drop
	logic ackIn, accEnd, canIssue;
	logic useSrc, useDst;

	// Op 0, 5, A, F ignore source; dest needed when op uses it or a mask keeps bits
	assign useSrc = hop[1] & (op[3:2] != op[1:0]);
	assign useDst = forceDstRd | (op[3] ^ op[2]) | (op[1] ^ op[0]);

	assign ackIn = memReq & memAck;
	assign accEnd = reqDone & !memAck;			// Access closed
	assign canIssue = !memReq & !reqDone & !memAck;

	always_comb begin
		if (useSrc)
			firstState = SRdSrc;
		else
			firstState = useDst ? SRdDst : SWrDst;

		case (state)
			SRdSrc: nextState = useDst ? SRdDst : SWrDst;
			SRdDst: nextState = SWrDst;
			default: nextState = firstState;		// Next word
		endcase
	end

	// Strobes while ack is high and read data valid
	assign srcDone = ackIn & (state == SRdSrc);
	assign dstLatch = ackIn & (state == SRdDst);
	assign dstDone = ackIn & (state == SWrDst);
	assign srcPhase = (state == SRdSrc);

	always_ff @(posedge Clks) begin
		if (rst) begin
			state <= SIdle;
			memReq <= 1'b0;
			memWr <= 1'b0;
			reqDone <= 1'b0;
		end else begin
			// Handshake closes on its own, even after a restart
			if (ackIn) begin
				memReq <= 1'b0;
				reqDone <= 1'b1;
			end else if (accEnd)
				reqDone <= 1'b0;

			if (blitReset)
				state <= SIdle;
			else if (state == SIdle) begin
				if (busy & canIssue)
					state <= firstState;
			end else if (accEnd)
				state <= busy ? nextState : SIdle;
			else if (canIssue) begin
				if (busy) begin
					memReq <= 1'b1;
					memWr <= (state == SWrDst);
				end else
					state <= SIdle;		// Stopped between accesses
			end
		end
	end

	always_ff @(posedge Clks) begin
		if (canIssue)
			memWrData <= blitWord;		// Held through the handshake
	end

endmodule

`default_nettype wire

// ==== hdl/stBlitter.sv ====
/*
 * Word based bit blitter, top level
 * Host register port in, four-phase memory master port out
 */
`timescale 1ns/1ps
`default_nettype none

module stBlitter #(
	parameter int AddrBits = 23
) (
	input wire Clks,
	input wire rst,
	input wire hostSel,
	input wire hostWr,
	input wire bltPkg::regIdxT hostIdx,
	input wire bltPkg::dataT hostWrData,
	input wire memAck,
	input wire bltPkg::dataT memRdData,
	output wire bltPkg::dataT hostRdData,
	output wire busy,
	output wire memReq,
	output wire memWr,
	output wire [AddrBits-1:0] memAddr,
	output wire bltPkg::dataT memWrData
);
	import bltPkg::*;

	logic [AddrBits-1:0] srcAddr, dstAddr;
	dataT xCount, yCount, addrLoadVal;
	dataT maskL, maskC, maskR, blitWord;
	incrT srcXinc, srcYinc, dstXinc, dstYinc;
	hopT hop;
	opT op;
	logic [LineBits-1:0] lineNum;
	logic addrLoadSel, blitReset, htWrEn;
	logic srcDone, dstDone, srcPhase, dstLatch;
	logic lastX, blitEnd, forceDstRd;

	bltRegs #(.AddrBits(AddrBits)) bltRegs_inst (
		.Clks, .rst, .hostSel, .hostWr, .hostIdx, .hostWrData,
		.srcAddr, .dstAddr, .xCount, .yCount, .dstDone, .lastX, .blitEnd,
		.hostRdData, .srcXinc, .srcYinc, .dstXinc, .dstYinc,
		.addrLoadVal, .addrLoadSel, .maskL, .maskC, .maskR, .hop, .op,
		.lineNum, .busy, .blitReset, .htWrEn
	);

	bltAddrGen #(.AddrBits(AddrBits)) bltAddrGen_inst (
		.Clks, .rst, .hostIdx, .hostWrData(addrLoadVal), .addrLoadSel,
		.srcXinc, .srcYinc, .dstXinc, .dstYinc, .srcDone, .dstDone, .srcPhase,
		.srcAddr, .dstAddr, .memAddr, .xCount, .yCount, .lastX, .blitEnd
	);

	bltCore bltCore_inst (
		.Clks, .rst, .htWrEn, .hostIdx, .hostWrData, .lineNum,
		.maskL, .maskC, .maskR, .hop, .op, .memRdData,
		.srcDone, .dstLatch, .dstDone, .lastX, .blitReset,
		.forceDstRd, .blitWord
	);

	bltSequencer bltSequencer_inst (
		.Clks, .rst, .busy, .blitReset, .hop, .op, .forceDstRd, .memAck, .blitWord,
		.memReq, .memWr, .memWrData, .srcDone, .dstDone, .srcPhase, .dstLatch
	);

endmodule

`default_nettype wire

// ==== tb/stBlitter_chk.sv ====
/*
 * Memory handshake checker, bound into the blitter sequencer
 * Four-phase req/ack rules and the state after reset
 */
`timescale 1ns/1ps
`default_nettype none

module stBlitter_chk (
	input wire Clks,
	input wire rst,
	input wire busy,
	input wire memReq,
	input wire memAck,
	input wire memWr,
	input wire bltPkg::dataT memWrData
);

	int breaches = 0;		// Failed assertions, summed up by the testbench

	// Request held until the memory answers
	reqHold: assert property (@(posedge Clks) disable iff (rst)
		memReq && !memAck |=> memReq)
	else begin
		$error("memReq dropped before memAck was seen");
		breaches++;
	end

	// Third phase follows the ack
	reqDrop: assert property (@(posedge Clks) disable iff (rst)
		memReq && memAck |=> !memReq)
	else begin
		$error("memReq still high one cycle after memAck");
		breaches++;
	end

	// New request only once ack is low, ack seen on the edge that raised it
	reqStart: assert property (@(posedge Clks) disable iff (rst)
		$rose(memReq) |-> !$past(memAck))
	else begin
		$error("memReq rose while memAck was still high");
		breaches++;
	end

	wrStable: assert property (@(posedge Clks) disable iff (rst)
		memReq && $past(memReq) |-> $stable(memWr))
	else begin
		$error("memWr changed during an open request");
		breaches++;
	end

	dataStable: assert property (@(posedge Clks) disable iff (rst)
		memReq && $past(memReq) && memWr |-> $stable(memWrData))
	else begin
		$error("memWrData changed during an open write");
		breaches++;
	end

	// Quiet port and idle flag out of reset
	resetState: assert property (@(posedge Clks)
		rst |=> !memReq && !memWr && !busy)
	else begin
		$error("memReq, memWr or busy high after reset");
		breaches++;
	end

endmodule

`default_nettype wire

// ==== tb/stBlitter_tb.sv ====
/*
 * Blitter testbench
 * Host register tasks, four-phase memory model with random ack delay,
 * reference blit model and per test reporting
 */
`timescale 1ns/1ps
`default_nettype none

module stBlitter_tb;
	import bltPkg::*;

	localparam int AddrBits = 23;
	// Six blits of at most 16 words run, 3 accesses of up to 9 cycles, doubled, plus host traffic
	localparam int MaxCycles = 6000;

	logic Clks, rst;
	logic hostSel, hostWr;
	regIdxT hostIdx;
	dataT hostWrData, hostRdData;
	logic busy, memReq, memWr, memAck;
	logic [AddrBits-1:0] memAddr;
	dataT memWrData, memRdData;

	dataT mem [256];			// Memory model, low address bits only
	dataT refMem [256];			// Expected contents after a blit
	dataT htTab [16];
	int rdLog[$], wrLog[$];		// Addresses as seen by the memory
	int expRd[$], expWr[$];
	int ackDelay, reqRises, seedVal;
	int cycles = 0;
	logic reqSeen;
	int testErrs, testsOk, testsBad;

	// Blit setup, addresses and increments in words
	int srcW, dstW, sXi, sYi, dXi, dYi, xCnt, yCnt, lineStart;
	hopT cfgHop;
	opT cfgOp;
	dataT mL, mC, mR;

	stBlitter #(.AddrBits(AddrBits)) stBlitter_inst (
		.Clks, .rst, .hostSel, .hostWr, .hostIdx, .hostWrData, .memAck, .memRdData,
		.hostRdData, .busy, .memReq, .memWr, .memAddr, .memWrData
	);

	bind bltSequencer stBlitter_chk handshakeChk (
		.Clks(Clks), .rst(rst), .busy(busy), .memReq(memReq), .memAck(memAck),
		.memWr(memWr), .memWrData(memWrData)
	);

	initial begin
		Clks = 1'b0;
		forever #50 Clks = ~Clks;
	end

	always @(posedge Clks) begin
		cycles++;
		if (cycles >= MaxCycles) begin
			$display("Timeout: run did not finish within %0d cycles", MaxCycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Counts request rises, sampled away from the active edge
	always @(negedge Clks) begin
		if (memReq && !reqSeen)
			reqRises++;
		reqSeen = memReq;
	end

	// Four-phase slave, ack after 0..3 idle cycles
	initial begin
		seedVal = 67015;
		seedVal = $urandom(seedVal);		// One seed for the whole run
		forever begin
			@(posedge Clks);
			if (rst) begin
				memAck <= 1'b0;
				ackDelay <= 0;
			end else if (memAck) begin
				if (!memReq) begin
					memAck <= 1'b0;						// Fourth phase
					ackDelay <= $urandom_range(3, 0);	// Latency of the next access
				end
			end else if (memReq) begin
				if (ackDelay != 0)
					ackDelay <= ackDelay - 1;
				else begin
					memAck <= 1'b1;
					if (memWr) begin
						mem[memAddr[7:0]] <= memWrData;
						wrLog.push_back(int'(memAddr[7:0]));
					end else begin
						memRdData <= mem[memAddr[7:0]];	// Valid while ack high
						rdLog.push_back(int'(memAddr[7:0]));
					end
				end
			end
		end
	end

	// Odd multiplier, so every address gets its own word
	function automatic dataT fillWord(input int a);
		return dataT'(a * 16'h9E37) ^ 16'h5A5A;
	endfunction

	// Bits a register keeps on readback
	function automatic dataT legalBits(input regIdxT idx);
		case (idx)
			RegSrcHi, RegDstHi: return 16'h00FF;		// Top 8 of 23 address bits
			RegSrcXinc, RegSrcYinc, RegDstXinc, RegDstYinc, RegSrcLo, RegDstLo:
				return 16'hFFFE;					// Even byte values
			RegHopOp: return 16'h030F;
			RegCtrl: return 16'h0F00;			// Line field, busy left clear
			default: return 16'hFFFF;
		endcase
	endfunction

	// ST op as minterms: bit 0 s.d, bit 1 s.!d, bit 2 !s.d, bit 3 !s.!d
	function automatic logic opBit(input opT op, input logic s, input logic d);
		return (op[0] & s & d) | (op[1] & s & !d) | (op[2] & !s & d) | (op[3] & !s & !d);
	endfunction

	task automatic compareVal(input string name, input dataT exp, input dataT act);
		assert (act === exp) else begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			testErrs++;
		end
	endtask

	task automatic finishTest(input string name);
		$display("Test %s: %0d errors", name, testErrs);
		if (testErrs == 0)
			testsOk++;
		else
			testsBad++;
		testErrs = 0;
	endtask

	task automatic hostWrite(input regIdxT idx, input dataT val);
		@(posedge Clks);
		hostSel <= 1'b1;
		hostWr <= 1'b1;
		hostIdx <= idx;
		hostWrData <= val;
		@(posedge Clks);
		hostSel <= 1'b0;
		hostWr <= 1'b0;
	endtask

	task automatic hostRead(input regIdxT idx, output dataT val);
		@(posedge Clks);
		hostSel <= 1'b1;
		hostWr <= 1'b0;
		hostIdx <= idx;
		@(posedge Clks);
		hostSel <= 1'b0;
		@(negedge Clks);
		val = hostRdData;		// Registered one cycle after the read
	endtask

	task automatic setGeometry(input int s, d, sx, sy, dx, dy, xc, yc);
		srcW = s;
		dstW = d;
		sXi = sx;
		sYi = sy;
		dXi = dx;
		dYi = dy;
		xCnt = xc;
		yCnt = yc;
	endtask

	// Expected accesses and memory, word by word in blit order
	task automatic modelBlit();
		int sA, dA, ln, x, y, i;
		logic useS, useD, last;
		dataT s, d, opnd, m, res;
		expRd.delete();
		expWr.delete();
		refMem = mem;
		sA = srcW;
		dA = dstW;
		ln = lineStart;
		s = '0;
		useS = cfgHop[1] && !(cfgOp inside {4'h0, 4'h5, 4'hA, 4'hF});
		for (y = 0; y < yCnt; y++) begin
			for (x = 0; x < xCnt; x++) begin
				last = (x == xCnt - 1);
				m = (x == 0) ? mL : (last ? mR : mC);		// One word line takes left
				useD = !(cfgOp inside {4'h0, 4'h3, 4'hC, 4'hF}) || (m != 16'hFFFF);
				if (useS) begin
					expRd.push_back(sA);
					s = refMem[sA];
					sA += last ? sYi : sXi;
				end
				if (useD)
					expRd.push_back(dA);
				d = refMem[dA];
				case (cfgHop)
					2'd0: opnd = '1;
					2'd1: opnd = htTab[ln];
					2'd2: opnd = s;
					default: opnd = s & htTab[ln];
				endcase
				for (i = 0; i < DataBits; i++)
					res[i] = m[i] ? opBit(cfgOp, opnd[i], d[i]) : d[i];
				refMem[dA] = res;
				expWr.push_back(dA);
				dA += last ? dYi : dXi;
			end
			ln = (dYi < 0) ? (ln + 15) % 16 : (ln + 1) % 16;	// Line counter direction
		end
	endtask

	task automatic startBlit();
		rdLog.delete();
		wrLog.delete();
		hostWrite(RegSrcXinc, dataT'(sXi * 2));		// Increments in bytes
		hostWrite(RegSrcYinc, dataT'(sYi * 2));
		hostWrite(RegSrcHi, dataT'(srcW >> 15));
		hostWrite(RegSrcLo, dataT'(srcW * 2));
		hostWrite(RegMaskL, mL);
		hostWrite(RegMaskC, mC);
		hostWrite(RegMaskR, mR);
		hostWrite(RegDstXinc, dataT'(dXi * 2));
		hostWrite(RegDstYinc, dataT'(dYi * 2));
		hostWrite(RegDstHi, dataT'(dstW >> 15));
		hostWrite(RegDstLo, dataT'(dstW * 2));
		hostWrite(RegXcount, dataT'(xCnt));
		hostWrite(RegYcount, dataT'(yCnt));			// Also restarts on a left word
		hostWrite(RegHopOp, {6'd0, cfgHop, 4'd0, cfgOp});
		hostWrite(RegCtrl, {1'b1, 3'd0, 4'(lineStart), 8'd0});
	endtask

	task automatic waitIdle();
		@(negedge Clks);
		while (busy)
			@(negedge Clks);
		while (memReq || memAck)		// Last handshake closes
			@(negedge Clks);
	endtask

	task automatic checkBlit(input string name);
		int a;
		compareVal({name, " read count"}, dataT'(expRd.size()), dataT'(rdLog.size()));
		compareVal({name, " write count"}, dataT'(expWr.size()), dataT'(wrLog.size()));
		foreach (expRd[i])
			if (i < rdLog.size())
				compareVal($sformatf("%s read %0d", name, i), dataT'(expRd[i]), dataT'(rdLog[i]));
		foreach (expWr[i])
			if (i < wrLog.size())
				compareVal($sformatf("%s write %0d", name, i), dataT'(expWr[i]),
					dataT'(wrLog[i]));
		for (a = 0; a < 256; a++)
			compareVal($sformatf("%s word %02h", name, a), refMem[a], mem[a]);
	endtask

	task automatic runBlit(input string name);
		modelBlit();
		startBlit();
		waitIdle();
		checkBlit(name);
		finishTest(name);
	endtask

	initial begin
		int i, rises;
		dataT rd;
		rst = 1'b1;
		hostSel = 1'b0;
		hostWr = 1'b0;
		hostIdx = '0;
		hostWrData = '0;
		memAck = 1'b0;
		memRdData = '0;
		reqSeen = 1'b0;
		reqRises = 0;
		testErrs = 0;
		testsOk = 0;
		testsBad = 0;
		for (i = 0; i < 256; i++)
			mem[i] = fillWord(i);
		repeat (5) @(posedge Clks);
		rst <= 1'b0;
		@(negedge Clks);

		compareVal("readback busy after reset", 16'h0000, dataT'(busy));
		for (i = RegSrcXinc; i <= RegCtrl; i++)
			hostWrite(regIdxT'(i), dataT'(i * 16'h2D4B) & legalBits(regIdxT'(i)));
		for (i = RegSrcXinc; i <= RegCtrl; i++) begin
			hostRead(regIdxT'(i), rd);
			compareVal($sformatf("readback reg %0d", i),
				dataT'(i * 16'h2D4B) & legalBits(regIdxT'(i)), rd);
		end
		finishTest("readback");

		// Endmasks first, so both operand buffers hold real data afterwards
		setGeometry(8'h00, 8'h40, 1, 13, 1, 13, 4, 2);
		cfgHop = 2'd2;
		cfgOp = 4'h3;
		mL = 16'h0FFF;
		mC = 16'hFFFF;
		mR = 16'hF000;
		lineStart = 0;
		runBlit("endmask");

		setGeometry(8'h84, 8'h24, 1, 13, 1, 13, 4, 3);	// Plain copy
		mL = 16'hFFFF;
		mR = 16'hFFFF;
		runBlit("copy");

		for (i = 0; i < 16; i++) begin
			htTab[i] = dataT'(16'hA5C3 ^ (i * 16'h1357));
			hostWrite(regIdxT'(i), htTab[i]);
		end
		setGeometry(8'h00, 8'hF0, 1, 13, 1, -18, 3, 4);	// Dest lines step downward
		cfgHop = 2'd1;
		lineStart = 2;									// Wraps past line 0
		runBlit("halftone");

		setGeometry(8'h88, 8'h08, 1, 14, 1, 14, 3, 2);
		cfgHop = 2'd2;
		cfgOp = 4'h0;
		lineStart = 0;
		runBlit("const zero");
		setGeometry(8'h88, 8'hB8, 1, 14, 1, 14, 3, 2);
		cfgOp = 4'hF;
		runBlit("const ones");

		// Long copy halted after a few writes
		setGeometry(8'h00, 8'h80, 1, 1, 1, 1, 8, 4);
		cfgOp = 4'h3;
		startBlit();
		@(negedge Clks);
		while (wrLog.size() < 3)
			@(negedge Clks);
		hostWrite(RegCtrl, 16'h0000);
		@(negedge Clks);
		compareVal("stop busy", 16'h0000, dataT'(busy));
		while (memReq || memAck)
			@(negedge Clks);
		rises = reqRises;
		repeat (40) @(negedge Clks);
		compareVal("stop request count", dataT'(rises), dataT'(reqRises));
		finishTest("stop");

		$display("Tests ok %0d, tests with errors %0d, handshake breaches %0d",
			testsOk, testsBad, stBlitter_inst.bltSequencer_inst.handshakeChk.breaches);
		if (testsBad == 0 && stBlitter_inst.bltSequencer_inst.handshakeChk.breaches == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== stBlitter.f ====
hdl/bltPkg.sv
hdl/bltRegs.sv
hdl/bltAddrGen.sv
hdl/bltCore.sv
hdl/bltSequencer.sv
hdl/stBlitter.sv
tb/stBlitter_chk.sv
tb/stBlitter_tb.sv
